//--- src/gb_bus_pkg.sv
// --------------------------------------------------
// memory map, register addresses and sizes for the
// DMG bus glue; DMG mode only, no colour registers
// --------------------------------------------------

package gb_bus_pkg;

	// --------------------------------------------------
	// bus types
	typedef logic [15:0] addr_t;      // cpu address
	typedef logic [7:0]  byte_t;      // data byte
	typedef logic [4:0]  irq_bits_t;  // vblank, lcd, timer, serial, joypad (bit 0 first)

	// --------------------------------------------------
	// io register addresses
	localparam addr_t ADDR_JOYP     = 16'hFF00;  // P1
	localparam addr_t ADDR_SB       = 16'hFF01;  // serial data
	localparam addr_t ADDR_SC       = 16'hFF02;  // serial control
	localparam addr_t ADDR_IF       = 16'hFF0F;
	localparam addr_t ADDR_BOOT_OFF = 16'hFF50;  // boot overlay off
	localparam addr_t ADDR_IE       = 16'hFFFF;

	// interrupt vectors, 40 + 8 * priority level
	localparam byte_t IRQ_VEC_BASE = 8'h40;
	localparam byte_t IRQ_VEC_STEP = 8'h08;
	localparam byte_t IRQ_VEC_NONE = 8'h55;  // ack with nothing pending

	localparam byte_t OPEN_BUS       = 8'hFF;
	localparam byte_t FAST_BOOT_FLAG = 8'h42;  // seen by the boot code in FF50

	// --------------------------------------------------
	// ram sizes
	localparam int ZP_AW   = 7;   // 127 used bytes at FF80
	localparam int IRAM_AW = 13;  // 8 KB at C000, echoed at E000

	// serial timer, about 8 kHz shift clock from clk_cpu
	localparam logic [8:0] SER_DIV_LOAD = 9'd511;
	localparam logic [3:0] SER_BITS     = 4'd8;

endpackage

//--- src/gb_addr_decode.sv
// --------------------------------------------------
// address decode, write strobes and read mux
// register reads are combinational, ram data is one
// edge late, so hold the address for two edges
// --------------------------------------------------
`timescale 1ns/10ps

module gb_addr_decode (
	input  gb_bus_pkg::addr_t     cpu_addr,
	input  logic                  cpu_wr,
	input  logic                  irq_ack,
	input  gb_bus_pkg::byte_t     irq_vec,
	input  gb_bus_pkg::irq_bits_t if_do,
	input  gb_bus_pkg::irq_bits_t ie_do,
	input  gb_bus_pkg::byte_t     joy_do,
	input  gb_bus_pkg::byte_t     sc_do,
	input  gb_bus_pkg::byte_t     zp_do,
	input  gb_bus_pkg::byte_t     iram_do,
	input  gb_bus_pkg::byte_t     rom_do,
	input  gb_bus_pkg::byte_t     boot_reg_do,
	output gb_bus_pkg::byte_t     cpu_di,
	output logic                  sel_rom_area,
	output logic                  wr_joyp,
	output logic                  wr_sc,
	output logic                  wr_if,
	output logic                  wr_ie,
	output logic                  wr_boot,
	output logic                  wr_zp,
	output logic                  wr_iram
);

	// --------------------------------------------------
	// region selects
	wire sel_rom  = ~cpu_addr[15];                 // 0000-7FFF
	wire sel_cram = cpu_addr[15:13] == 3'b101;     // cart ram A000-BFFF
	wire sel_iram = (cpu_addr[15:14] == 2'b11) && ~&cpu_addr[13:9];  // C000-FDFF
	wire sel_zp   = (cpu_addr[15:7] == 9'h1FF) && (cpu_addr != gb_bus_pkg::ADDR_IE);

	// single registers
	wire sel_joy  = cpu_addr == gb_bus_pkg::ADDR_JOYP;
	wire sel_sb   = cpu_addr == gb_bus_pkg::ADDR_SB;
	wire sel_sc   = cpu_addr == gb_bus_pkg::ADDR_SC;
	wire sel_if   = cpu_addr == gb_bus_pkg::ADDR_IF;
	wire sel_boot = cpu_addr == gb_bus_pkg::ADDR_BOOT_OFF;
	wire sel_ie   = cpu_addr == gb_bus_pkg::ADDR_IE;

	assign sel_rom_area = sel_rom | sel_cram;  // both go out to the cartridge

	// write strobes, SB has none since there is no link partner
	assign wr_joyp = cpu_wr & sel_joy;
	assign wr_sc   = cpu_wr & sel_sc;
	assign wr_if   = cpu_wr & sel_if;
	assign wr_ie   = cpu_wr & sel_ie;
	assign wr_boot = cpu_wr & sel_boot;
	assign wr_zp   = cpu_wr & sel_zp;
	assign wr_iram = cpu_wr & sel_iram;

	// --------------------------------------------------
	// read mux, first match wins
	always_comb begin
		if (irq_ack)           cpu_di = irq_vec;          // ack cycle returns the vector
		else if (sel_boot)     cpu_di = boot_reg_do;
		else if (sel_if)       cpu_di = {3'b111, if_do};  // unused bits read high
		else if (sel_joy)      cpu_di = joy_do;
		else if (sel_sb)       cpu_di = gb_bus_pkg::OPEN_BUS;
		else if (sel_sc)       cpu_di = sc_do;
		else if (sel_rom_area) cpu_di = rom_do;
		else if (sel_zp)       cpu_di = zp_do;
		else if (sel_iram)     cpu_di = iram_do;
		else if (sel_ie)       cpu_di = {3'b000, ie_do};
		else                   cpu_di = gb_bus_pkg::OPEN_BUS;
	end

	// regions must not overlap, else two blocks take one write
	always_comb begin
		assert final ($onehot0({wr_joyp, wr_sc, wr_if, wr_ie, wr_boot, wr_zp, wr_iram}))
			else $error("more than one write strobe at %h", cpu_addr);
	end

endmodule

//--- src/gb_irq_ctrl.sv
// --------------------------------------------------
// IF/IE registers and interrupt vector
// event inputs are levels, an IF bit sets two edges
// after a rise; cpu writes win over events and ack
// --------------------------------------------------
`timescale 1ns/10ps

module gb_irq_ctrl (
	input  logic                  clk_cpu,
	input  logic                  reset_r,
	input  logic                  vblank_irq,
	input  logic                  video_irq,
	input  logic                  timer_irq,
	input  logic                  serial_irq,
	input  logic [3:0]            joy_din,
	input  logic                  irq_ack,
	input  logic                  wr_if,
	input  logic                  wr_ie,
	input  gb_bus_pkg::byte_t     cpu_do,
	output gb_bus_pkg::irq_bits_t if_do,
	output gb_bus_pkg::irq_bits_t ie_do,
	output gb_bus_pkg::byte_t     irq_vec,
	output logic                  irq_n
);

	gb_bus_pkg::irq_bits_t if_r;
	gb_bus_pkg::irq_bits_t ie_r;
	gb_bus_pkg::irq_bits_t if_next;
	gb_bus_pkg::irq_bits_t pend;
	gb_bus_pkg::irq_bits_t win_mask;
	logic [3:0] ev_s1, ev_s2;    // sync stage, compare stage
	logic [3:0] joy_s1, joy_s2;
	logic       ack_d;
	logic [2:0] win_idx;
	logic       win_hit;

	wire [3:0] ev_in   = {serial_irq, timer_irq, video_irq, vblank_irq};
	wire [3:0] ev_rise = ev_s1 & ~ev_s2;
	wire       joy_fall = |(~joy_s1 & joy_s2);   // any line pulled low
	wire       ack_fall = ack_d & ~irq_ack;

	assign pend = if_r & ie_r;

	// --------------------------------------------------
	// priority pick where the lowest index wins
	always_comb begin
		win_idx = 3'd0;
		win_hit = 1'b0;
		for (int i = 4; i >= 0; i--) begin
			if (pend[i]) begin
				win_idx = 3'(i);
				win_hit = 1'b1;
			end
		end
		win_mask = win_hit ? gb_bus_pkg::irq_bits_t'(5'b00001 << win_idx) : '0;
		irq_vec  = win_hit ? gb_bus_pkg::IRQ_VEC_BASE
			+ gb_bus_pkg::IRQ_VEC_STEP * gb_bus_pkg::byte_t'(win_idx)
			: gb_bus_pkg::IRQ_VEC_NONE;
	end

	// clear first so an event on the ack edge is kept
	always_comb begin
		if_next = if_r;
		if (ack_fall)
			if_next = if_next & ~win_mask;
		if_next = if_next | {joy_fall, ev_rise};
		if (wr_if)
			if_next = cpu_do[4:0];  // cpu write overrides
	end

	always_ff @(posedge clk_cpu) begin
		if (reset_r) begin
			ev_s1  <= '0;
			ev_s2  <= '0;
			joy_s1 <= 4'hF;  // lines idle high
			joy_s2 <= 4'hF;
			ack_d  <= 1'b0;
			if_r   <= '0;
			ie_r   <= '0;
		end else begin
			ev_s1  <= ev_in;
			ev_s2  <= ev_s1;
			joy_s1 <= joy_din;
			joy_s2 <= joy_s1;
			ack_d  <= irq_ack;
			if_r   <= if_next;
			if (wr_ie)
				ie_r <= cpu_do[4:0];
		end
	end

	assign if_do = if_r;
	assign ie_do = ie_r;
	assign irq_n = ~|pend;

	// ack clears the bit it vectored to unless the same event fires again
	assert property (@(posedge clk_cpu) disable iff (reset_r)
		ack_fall && !wr_if && !(|(win_mask & {joy_fall, ev_rise}))
		|=> !(|(if_r & $past(win_mask))))
		else $error("acknowledged IF bit not cleared");

endmodule

//--- src/gb_io_regs.sv
// --------------------------------------------------
// joypad select and internal-clock serial timer
// no link partner, so only the timing of a transfer
// is modelled; external clock mode never finishes
// --------------------------------------------------
`timescale 1ns/10ps

module gb_io_regs (
	input  logic              clk_cpu,
	input  logic              reset_r,
	input  logic              wr_joyp,
	input  logic              wr_sc,
	input  gb_bus_pkg::byte_t cpu_do,
	input  logic [3:0]        joy_din,
	output logic [1:0]        joy_p54,
	output gb_bus_pkg::byte_t joy_do,
	output gb_bus_pkg::byte_t sc_do,
	output logic              serial_irq
);

	logic [1:0] p54;
	logic       sc_start;   // SC bit 7
	logic       sc_clk;     // SC bit 0, internal clock
	logic [8:0] ser_div;
	logic [3:0] ser_cnt;    // bits left

	// --------------------------------------------------
	// joypad select
	always_ff @(posedge clk_cpu) begin
		if (reset_r)
			p54 <= 2'b11;  // nothing selected
		else if (wr_joyp)
			p54 <= cpu_do[5:4];
	end

	assign joy_p54 = p54;
	assign joy_do  = {2'b11, p54, joy_din};

	// --------------------------------------------------
	// serial timer
	always_ff @(posedge clk_cpu) begin
		if (reset_r) begin
			sc_start   <= 1'b0;
			sc_clk     <= 1'b0;
			ser_div    <= '0;
			ser_cnt    <= '0;
			serial_irq <= 1'b0;
		end else begin
			serial_irq <= 1'b0;  // one cycle pulse
			if (wr_sc) begin
				sc_start <= cpu_do[7];
				sc_clk   <= cpu_do[0];
				if (cpu_do[7]) begin
					ser_div <= gb_bus_pkg::SER_DIV_LOAD;
					ser_cnt <= gb_bus_pkg::SER_BITS;
				end
			end else if (sc_start && sc_clk) begin
				ser_div <= ser_div - 9'd1;  // wraps to 511
				if (ser_div == 9'd0 && ser_cnt != 4'd0)
					ser_cnt <= ser_cnt - 4'd1;
				if (ser_cnt == 4'd0) begin
					serial_irq <= 1'b1;  // transfer done
					sc_start   <= 1'b0;
				end
			end
		end
	end

	assign sc_do = {sc_start, 6'h3F, sc_clk};

	// a transfer ends only by completion or by a cpu write
	assert property (@(posedge clk_cpu) disable iff (reset_r)
		$fell(sc_start) |-> serial_irq || $past(wr_sc))
		else $error("serial start bit dropped without irq or write");

endmodule

//--- src/gb_work_ram.sv
// --------------------------------------------------
// zero-page ram and 8 KB work ram
// synchronous read, data shows the previous address
// echo region shares the low 13 address bits
// --------------------------------------------------
`timescale 1ns/10ps

module gb_work_ram (
	input  logic              clk_cpu,
	input  gb_bus_pkg::addr_t cpu_addr,
	input  gb_bus_pkg::byte_t cpu_do,
	input  logic              wr_zp,
	input  logic              wr_iram,
	output gb_bus_pkg::byte_t zp_do,
	output gb_bus_pkg::byte_t iram_do
);

	gb_bus_pkg::byte_t zp_mem   [2**gb_bus_pkg::ZP_AW];
	gb_bus_pkg::byte_t iram_mem [2**gb_bus_pkg::IRAM_AW];

	wire [gb_bus_pkg::ZP_AW-1:0]   zp_a   = cpu_addr[gb_bus_pkg::ZP_AW-1:0];
	wire [gb_bus_pkg::IRAM_AW-1:0] iram_a = cpu_addr[gb_bus_pkg::IRAM_AW-1:0];

	// zero page, FFFF never reaches here
	always_ff @(posedge clk_cpu) begin
		if (wr_zp)
			zp_mem[zp_a] <= cpu_do;
		zp_do <= zp_mem[zp_a];  // read before write
	end

	// work ram
	always_ff @(posedge clk_cpu) begin
		if (wr_iram)
			iram_mem[iram_a] <= cpu_do;
		iram_do <= iram_mem[iram_a];
	end

	assert property (@(posedge clk_cpu) !(wr_zp && wr_iram))
		else $error("zero page and work ram written together");

endmodule

//--- src/gb_boot_ctrl.sv
// --------------------------------------------------
// boot rom overlay and cartridge steering
// boot rom covers 0000-00FF until FF50 bit 0 is set
// cart strobes follow cpu_rd and cpu_wr directly
// --------------------------------------------------
`timescale 1ns/10ps

module gb_boot_ctrl (
	input  logic              clk_cpu,
	input  logic              reset_r,
	input  gb_bus_pkg::addr_t cpu_addr,
	input  logic              cpu_rd,
	input  logic              cpu_wr,
	input  gb_bus_pkg::byte_t cpu_do,
	input  logic              wr_boot,
	input  logic              sel_rom_area,
	input  logic              fast_boot,
	input  gb_bus_pkg::byte_t cart_do,
	input  gb_bus_pkg::byte_t boot_rom_data,
	output gb_bus_pkg::byte_t rom_do,
	output gb_bus_pkg::byte_t boot_reg_do,
	output logic              cart_rd,
	output logic              cart_wr,
	output logic [7:0]        boot_rom_addr
);

	logic boot_on;  // overlay active

	// one-way switch, only reset turns it back on
	always_ff @(posedge clk_cpu) begin
		if (reset_r)
			boot_on <= 1'b1;
		else if (wr_boot && cpu_do[0])
			boot_on <= 1'b0;
	end

	wire boot_area = cpu_addr[15:8] == 8'h00;  // first 256 bytes

	assign rom_do        = (boot_area && boot_on) ? boot_rom_data : cart_do;
	assign boot_reg_do   = (fast_boot && boot_on) ? gb_bus_pkg::FAST_BOOT_FLAG
		: gb_bus_pkg::OPEN_BUS;
	assign boot_rom_addr = cpu_addr[7:0];

	// cart sees rom and cart ram cycles, overlay or not
	assign cart_rd = sel_rom_area & cpu_rd;
	assign cart_wr = sel_rom_area & cpu_wr;

endmodule

//--- src/gb_sys_bus.sv
// --------------------------------------------------
// DMG system bus glue, cpu and cartridge outside
// all state on the rising edge of clk_cpu
// --------------------------------------------------
`timescale 1ns/10ps

module gb_sys_bus (
	input  logic              clk_cpu,
	input  logic              reset_r,
	// cpu bus
	input  gb_bus_pkg::addr_t cpu_addr,
	input  gb_bus_pkg::byte_t cpu_do,
	input  logic              cpu_rd,
	input  logic              cpu_wr,
	input  logic              cpu_iorq_m1,  // interrupt ack
	output gb_bus_pkg::byte_t cpu_di,
	output logic              irq_n,
	// misc inputs
	input  logic              fast_boot,
	input  logic [3:0]        joy_din,
	output logic [1:0]        joy_p54,
	input  logic              vblank_irq,
	input  logic              video_irq,
	input  logic              timer_irq,
	// cartridge
	output gb_bus_pkg::addr_t cart_addr,
	output gb_bus_pkg::byte_t cart_di,
	output logic              cart_rd,
	output logic              cart_wr,
	input  gb_bus_pkg::byte_t cart_do,
	// boot rom
	output logic [7:0]        boot_rom_addr,
	input  gb_bus_pkg::byte_t boot_rom_data
);

	gb_bus_pkg::irq_bits_t if_do, ie_do;
	gb_bus_pkg::byte_t     irq_vec, joy_do, sc_do, zp_do, iram_do, rom_do, boot_reg_do;
	logic sel_rom_area, serial_irq;
	logic wr_joyp, wr_sc, wr_if, wr_ie, wr_boot, wr_zp, wr_iram;

	assign cart_addr = cpu_addr;
	assign cart_di   = cpu_do;

	gb_addr_decode i_decode (
		.cpu_addr, .cpu_wr, .irq_ack(cpu_iorq_m1), .irq_vec, .if_do, .ie_do,
		.joy_do, .sc_do, .zp_do, .iram_do, .rom_do, .boot_reg_do, .cpu_di,
		.sel_rom_area, .wr_joyp, .wr_sc, .wr_if, .wr_ie, .wr_boot, .wr_zp, .wr_iram
	);

	gb_irq_ctrl i_irq (
		.clk_cpu, .reset_r, .vblank_irq, .video_irq, .timer_irq, .serial_irq,
		.joy_din, .irq_ack(cpu_iorq_m1), .wr_if, .wr_ie, .cpu_do,
		.if_do, .ie_do, .irq_vec, .irq_n
	);

	gb_io_regs i_io (
		.clk_cpu, .reset_r, .wr_joyp, .wr_sc, .cpu_do, .joy_din,
		.joy_p54, .joy_do, .sc_do, .serial_irq
	);

	gb_work_ram i_ram (
		.clk_cpu, .cpu_addr, .cpu_do, .wr_zp, .wr_iram, .zp_do, .iram_do
	);

	gb_boot_ctrl i_boot (
		.clk_cpu, .reset_r, .cpu_addr, .cpu_rd, .cpu_wr, .cpu_do, .wr_boot,
		.sel_rom_area, .fast_boot, .cart_do, .boot_rom_data,
		.rom_do, .boot_reg_do, .cart_rd, .cart_wr, .boot_rom_addr
	);

endmodule

//--- tests/tb_gb_tasks.svh
// --------------------------------------------------
// bus cycles, compare and directed tests
// included inside tb_gb_sys_bus and drives its signals
// --------------------------------------------------
`ifndef TB_GB_TASKS_SVH
`define TB_GB_TASKS_SVH

// --------------------------------------------------
// bus cycles and checks
task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
	checks++;
	if (got !== exp) begin
		$display("ERROR %s: got %h, expected %h", name, got, exp);
		errors++;
	end
endtask

task automatic write_cycle(input gb_bus_pkg::addr_t a, input gb_bus_pkg::byte_t d);
	@(posedge clk_cpu);
	cpu_addr <= a;
	cpu_do   <= d;
	cpu_wr   <= 1'b1;
	@(posedge clk_cpu);  // write lands here
	cpu_wr   <= 1'b0;
endtask

// address held two edges since ram data is one edge late
task automatic read_cycle(input gb_bus_pkg::addr_t a, output gb_bus_pkg::byte_t d);
	@(posedge clk_cpu);
	cpu_addr <= a;
	cpu_rd   <= 1'b1;
	repeat (2) @(posedge clk_cpu);
	@(negedge clk_cpu);  // stable point
	d         = cpu_di;
	rd_strobe = cart_rd;
	@(posedge clk_cpu);
	cpu_rd <= 1'b0;
endtask

task automatic read_expect(input gb_bus_pkg::addr_t a, input gb_bus_pkg::byte_t exp);
	gb_bus_pkg::byte_t d;
	read_cycle(a, d);
	compare($sformatf("cpu_di at %h", a), d, exp);
endtask

// cartridge pins while a write to the rom area is held
task automatic cart_write_check(input gb_bus_pkg::addr_t a, input gb_bus_pkg::byte_t d);
	@(posedge clk_cpu);
	cpu_addr <= a;
	cpu_do   <= d;
	cpu_wr   <= 1'b1;
	@(negedge clk_cpu);
	compare("cart_wr", cart_wr, 1'b1);
	compare("cart_di", cart_di, d);
	compare("cart_addr hi", cart_addr[15:8], a[15:8]);
	compare("cart_addr lo", cart_addr[7:0], a[7:0]);
	@(posedge clk_cpu);
	cpu_wr <= 1'b0;
endtask

// vector read during iorq and the IF bit clears on the edge after it falls
task automatic ack_cycle(output gb_bus_pkg::byte_t vec);
	@(posedge clk_cpu);
	cpu_iorq_m1 <= 1'b1;
	@(negedge clk_cpu);
	vec = cpu_di;
	@(posedge clk_cpu);
	cpu_iorq_m1 <= 1'b0;
	@(posedge clk_cpu);  // clear edge
endtask

task automatic wait_irq_low(input int max_cyc);
	int n;
	n = 0;
	@(negedge clk_cpu);
	while (irq_n && n < max_cyc) begin
		@(negedge clk_cpu);
		n++;
	end
	if (irq_n) begin
		$display("irq_n stayed high for %0d cycles, no interrupt request seen", max_cyc);
		errors++;
	end
endtask

task automatic wait_serial_done(input int max_cyc);
	int n;
	n = 0;
	@(posedge clk_cpu);
	cpu_addr <= gb_bus_pkg::ADDR_SC;  // poll SC bit 7
	@(negedge clk_cpu);
	while (cpu_di[7] && n < max_cyc) begin
		@(negedge clk_cpu);
		n++;
	end
	if (cpu_di[7]) begin
		$display("serial transfer still busy after %0d cycles", max_cyc);
		errors++;
	end
endtask

task automatic report_test(input string name, input int errs_before);
	$display("test %s finished, %0d errors", name, errors - errs_before);
endtask

// --------------------------------------------------
// directed tests
task automatic reset_defaults();
	int e0;
	e0 = errors;
	@(negedge clk_cpu);
	compare("irq_n", irq_n, 1'b1);
	compare("cart_rd", cart_rd, 1'b0);
	compare("cart_wr", cart_wr, 1'b0);
	read_expect(gb_bus_pkg::ADDR_IF, 8'hE0);  // upper three read 1
	read_expect(gb_bus_pkg::ADDR_IE, 8'h00);
	read_expect(gb_bus_pkg::ADDR_JOYP, {2'b11, 2'b11, joy_din});
	read_expect(gb_bus_pkg::ADDR_SB, 8'hFF);
	read_expect(16'hFF7F, 8'hFF);  // hole just below zero page
	report_test("reset_defaults", e0);
endtask

task automatic ram_readback();
	int e0;
	gb_bus_pkg::addr_t wa [4];
	gb_bus_pkg::addr_t za [4];
	gb_bus_pkg::byte_t wd [4];
	gb_bus_pkg::byte_t zd [4];
	e0 = errors;
	for (int i = 0; i < 4; i++) begin
		wa[i] = 16'hC000 | (16'(i) << 9) | 16'($urandom & 32'h1FF);  // distinct slices
		za[i] = 16'hFF80 | (16'(i) << 4) | 16'($urandom & 32'hF);
		wd[i] = 8'($urandom);
		zd[i] = 8'($urandom);
		write_cycle(wa[i], wd[i]);
		write_cycle(za[i], zd[i]);
	end
	for (int i = 0; i < 4; i++) begin
		read_expect(wa[i], wd[i]);
		read_expect(za[i], zd[i]);
		read_expect(wa[i] + 16'h2000, wd[i]);  // echo at E000
	end
	report_test("ram_readback", e0);
endtask

task automatic boot_overlay();
	int e0;
	e0 = errors;
	@(posedge clk_cpu);
	fast_boot <= 1'b1;
	read_expect(gb_bus_pkg::ADDR_BOOT_OFF, 8'h42);
	read_expect(16'h0010, boot_model(8'h10));  // overlay on
	read_expect(16'h0150, cart_model(16'h0150));
	compare("cart_rd", rd_strobe, 1'b1);
	cart_write_check(16'h2001, 8'h5A);  // mbc register write
	write_cycle(gb_bus_pkg::ADDR_BOOT_OFF, 8'h01);
	read_expect(16'h0010, cart_model(16'h0010));
	read_expect(gb_bus_pkg::ADDR_BOOT_OFF, 8'hFF);
	report_test("boot_overlay", e0);
endtask

task automatic irq_priority();
	int e0;
	gb_bus_pkg::byte_t vec;
	e0 = errors;
	write_cycle(gb_bus_pkg::ADDR_IF, 8'h00);
	write_cycle(gb_bus_pkg::ADDR_IE, 8'h1F);
	@(posedge clk_cpu);
	timer_irq <= 1'b1;
	@(posedge clk_cpu);
	timer_irq <= 1'b0;
	wait_irq_low(8);
	@(posedge clk_cpu);
	vblank_irq <= 1'b1;
	@(posedge clk_cpu);
	vblank_irq <= 1'b0;
	read_expect(gb_bus_pkg::ADDR_IF, 8'hE5);  // timer and vblank
	@(negedge clk_cpu);
	compare("irq_n", irq_n, 1'b0);
	ack_cycle(vec);
	compare("irq vector", vec, 8'h40);  // vblank at level 0
	read_expect(gb_bus_pkg::ADDR_IF, 8'hE4);
	ack_cycle(vec);
	compare("irq vector", vec, 8'h50);  // timer at level 2
	@(negedge clk_cpu);
	compare("irq_n", irq_n, 1'b1);
	report_test("irq_priority", e0);
endtask

task automatic joypad_select();
	int e0;
	e0 = errors;
	write_cycle(gb_bus_pkg::ADDR_JOYP, 8'h10);
	@(negedge clk_cpu);
	compare("joy_p54", joy_p54, 2'b01);
	@(posedge clk_cpu);
	joy_din <= 4'b1101;  // one button down
	wait_irq_low(8);
	read_expect(gb_bus_pkg::ADDR_IF, 8'hF0);
	read_expect(gb_bus_pkg::ADDR_JOYP, {2'b11, 2'b01, 4'b1101});
	@(posedge clk_cpu);
	joy_din <= 4'hF;
	write_cycle(gb_bus_pkg::ADDR_IF, 8'h00);
	report_test("joypad_select", e0);
endtask

task automatic serial_transfer();
	int e0;
	gb_bus_pkg::byte_t d;
	e0 = errors;
	write_cycle(gb_bus_pkg::ADDR_SC, 8'h81);  // start with internal clock
	wait_serial_done(6000);
	read_cycle(gb_bus_pkg::ADDR_IF, d);
	compare("IF bit 3", d[3], 1'b1);
	read_expect(gb_bus_pkg::ADDR_SB, 8'hFF);  // nothing shifted in
	report_test("serial_transfer", e0);
endtask

`endif

//--- tests/tb_gb_sys_bus.sv
// --------------------------------------------------
// testbench for the DMG bus glue, directed tests
// cartridge and boot rom are xor models of the address
// a 1 ms guard ends a run that hangs
// --------------------------------------------------
`timescale 1ns/10ps

module tb_gb_sys_bus;

	logic              clk_cpu;
	logic              reset_r;
	gb_bus_pkg::addr_t cpu_addr;
	gb_bus_pkg::byte_t cpu_do;
	logic              cpu_rd;
	logic              cpu_wr;
	logic              cpu_iorq_m1;
	gb_bus_pkg::byte_t cpu_di;
	logic              irq_n;
	logic              fast_boot;
	logic [3:0]        joy_din;
	logic [1:0]        joy_p54;
	logic              vblank_irq;
	logic              video_irq;
	logic              timer_irq;
	gb_bus_pkg::addr_t cart_addr;
	gb_bus_pkg::byte_t cart_di;
	logic              cart_rd;
	logic              cart_wr;
	gb_bus_pkg::byte_t cart_do;
	logic [7:0]        boot_rom_addr;
	gb_bus_pkg::byte_t boot_rom_data;

	int          checks;     // compares done
	int          errors;     // compares failed plus timeouts
	logic        rd_strobe;  // cart_rd seen in the last read cycle

	gb_sys_bus i_dut (
		.clk_cpu, .reset_r, .cpu_addr, .cpu_do, .cpu_rd, .cpu_wr, .cpu_iorq_m1,
		.cpu_di, .irq_n, .fast_boot, .joy_din, .joy_p54, .vblank_irq, .video_irq,
		.timer_irq, .cart_addr, .cart_di, .cart_rd, .cart_wr, .cart_do,
		.boot_rom_addr, .boot_rom_data
	);

	// --------------------------------------------------
	// memory models
	function automatic gb_bus_pkg::byte_t cart_model(input gb_bus_pkg::addr_t a);
		return a[7:0] ^ 8'hA5;  // low byte only
	endfunction

	function automatic gb_bus_pkg::byte_t boot_model(input logic [7:0] a);
		return a ^ 8'h3C;
	endfunction

	assign cart_do       = cart_model(cart_addr);
	assign boot_rom_data = boot_model(boot_rom_addr);

	`include "tb_gb_tasks.svh"

	// 20 ns clock
	initial begin
		clk_cpu = 1'b0;
		forever #10 clk_cpu = ~clk_cpu;
	end

	// hang guard far beyond the ~4100 cycle serial test
	initial begin
		#1ms;
		$display("simulation ran past its time limit, tests did not finish");
		$display("ERRORS FOUND");
		$finish;
	end

	// --------------------------------------------------
	// test sequence
	initial begin
		checks = 0;
		errors = 0;
		rd_strobe = 1'b0;
		void'($urandom(32'hccfd));  // seed once
		reset_r     <= 1'b1;
		cpu_addr    <= '0;
		cpu_do      <= '0;
		cpu_rd      <= 1'b0;
		cpu_wr      <= 1'b0;
		cpu_iorq_m1 <= 1'b0;
		fast_boot   <= 1'b0;
		joy_din     <= 4'hF;  // no buttons
		vblank_irq  <= 1'b0;
		video_irq   <= 1'b0;
		timer_irq   <= 1'b0;
		repeat (8) @(posedge clk_cpu);
		reset_r <= 1'b0;

		reset_defaults();
		ram_readback();
		boot_overlay();
		irq_priority();
		joypad_select();
		serial_transfer();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+tests
src/gb_bus_pkg.sv
src/gb_addr_decode.sv
src/gb_irq_ctrl.sv
src/gb_io_regs.sv
src/gb_work_ram.sv
src/gb_boot_ctrl.sv
src/gb_sys_bus.sv
tests/tb_gb_sys_bus.sv

//--- Bender.yml
package:
  name: gb_sys_bus

sources:
  - src/gb_bus_pkg.sv
  - src/gb_addr_decode.sv
  - src/gb_irq_ctrl.sv
  - src/gb_io_regs.sv
  - src/gb_work_ram.sv
  - src/gb_boot_ctrl.sv
  - src/gb_sys_bus.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_gb_sys_bus.sv
